/* compile.f */
hw/exPkg.sv
hw/exLaneIf.sv
hw/scratchMem.sv
hw/exStage1.sv
hw/exStage2.sv
hw/exStage3.sv
hw/exLaneTop.sv
verif/exLane_assert.sv
verif/exLaneTb.sv

/* hw/exLaneIf.sv */
/*
 Execute lane link
 Valid/ready handshake plus op fields between two lane stages
*/
`timescale 1ns/1ps

interface exLaneIf;

	logic          valid;
	logic          ready;
	exPkg::opCmd   cmd;
	exPkg::gprId   idRm;	// Destination
	exPkg::gprVal  val;		// Result, or load address for MOVMR
	exPkg::gprVal  memData;	// Load data, s23 only
	logic          flush;	// Set at entry, rides with the op

	modport src (
		output valid, cmd, idRm, val, memData, flush,
		input  ready
	);

	modport dst (
		input  valid, cmd, idRm, val, memData, flush,
		output ready
	);

endinterface

/* hw/exLaneTop.sv */
/*
 Execute lane top
 Three stages chained by two valid/ready links
*/
`timescale 1ns/1ps

module exLaneTop (
	input  logic          clock,
	input  logic          rst,
	input  logic          inValid,
	output logic          inReady,
	input  exPkg::opCmd   inCmd,
	input  exPkg::gprId   inIdRm,
	input  exPkg::gprVal  inValRs,
	input  exPkg::gprVal  inValRt,
	input  exPkg::immVal  inImm,
	input  logic          inFlush,
	output logic          wbValid,
	input  logic          wbReady,
	output exPkg::gprId   wbIdRn2,
	output exPkg::gprVal  wbValRn2,
	output exPkg::gprId   wbIdRn4,
	output exPkg::gprVal  wbValRn4,
	output logic          wbHeld,
	output logic          wbBadCmd,
	input  logic          memWrEn,
	input  exPkg::memIdx  memWrIdx,
	input  exPkg::gprVal  memWrData
);

	exLaneIf s12 ();	// Stage 1 to buffer
	exLaneIf s23 ();	// Buffer head to write-back

	exStage1 uStage1 (
		.clock   (clock),
		.rst     (rst),
		.inValid (inValid),
		.inReady (inReady),
		.inCmd   (inCmd),
		.inIdRm  (inIdRm),
		.inValRs (inValRs),
		.inValRt (inValRt),
		.inImm   (inImm),
		.inFlush (inFlush),
		.out     (s12.src)
	);

	exStage2 uStage2 (
		.clock     (clock),
		.rst       (rst),
		.in        (s12.dst),
		.out       (s23.src),
		.memWrEn   (memWrEn),
		.memWrIdx  (memWrIdx),
		.memWrData (memWrData)
	);

	exStage3 uStage3 (
		.clock    (clock),
		.rst      (rst),
		.in       (s23.dst),
		.wbValid  (wbValid),
		.wbReady  (wbReady),
		.wbIdRn2  (wbIdRn2),
		.wbIdRn4  (wbIdRn4),
		.wbValRn2 (wbValRn2),
		.wbValRn4 (wbValRn4),
		.wbHeld   (wbHeld),
		.wbBadCmd (wbBadCmd)
	);

endmodule

/* hw/exPkg.sv */
/*
 Execute lane package
 Field widths, micro-op command codes, zero register id and buffer sizing
*/
package exPkg;

	localparam int CMD_W     = 6;	// Micro-op command
	localparam int GPR_ID_W  = 6;	// Register id
	localparam int VAL_W     = 64;	// Register / result value
	localparam int IMM_W     = 33;	// Decoded immediate, pre sign-extension
	localparam int MEM_IDX_W = 4;	// Scratch word index

	localparam int MEM_WORDS    = 16;
	localparam int MEM_ADDR_LSB = 3;	// Byte address to 64-bit word index

	// Stage-2 buffer sizing
	localparam int BUF_DEPTH = 2;
	localparam int BUF_PTR_W = $clog2(BUF_DEPTH);
	localparam int BUF_CNT_W = $clog2(BUF_DEPTH + 1);	// Needs to hold BUF_DEPTH itself

	typedef logic [CMD_W-1:0]     opCmd;
	typedef logic [GPR_ID_W-1:0]  gprId;
	typedef logic [VAL_W-1:0]     gprVal;
	typedef logic [IMM_W-1:0]     immVal;
	typedef logic [MEM_IDX_W-1:0] memIdx;
	typedef logic [BUF_PTR_W-1:0] bufPtr;
	typedef logic [BUF_CNT_W-1:0] bufCnt;

	// Command codes; anything else is unknown
	localparam opCmd CMD_NOP   = 6'h00;
	localparam opCmd CMD_ADD   = 6'h01;
	localparam opCmd CMD_SUB   = 6'h02;	// Rs - Rt
	localparam opCmd CMD_AND   = 6'h03;
	localparam opCmd CMD_OR    = 6'h04;
	localparam opCmd CMD_XOR   = 6'h05;
	localparam opCmd CMD_MOVIR = 6'h06;	// Rm = sext(imm)
	localparam opCmd CMD_MOVMR = 6'h07;	// Rm = mem[Rs + sext(imm)]

	localparam gprId GR_ZZR = 6'd0;	// Zero register, writes discarded

endpackage

/* hw/exStage1.sv */
/*
 Execute stage 1
 ALU results, immediate moves and load address generation, one op register
*/
`timescale 1ns/1ps

module exStage1 (
	input  logic          clock,
	input  logic          rst,
	input  logic          inValid,
	output logic          inReady,
	input  exPkg::opCmd   inCmd,
	input  exPkg::gprId   inIdRm,
	input  exPkg::gprVal  inValRs,
	input  exPkg::gprVal  inValRt,
	input  exPkg::immVal  inImm,
	input  logic          inFlush,
	exLaneIf.src          out
);

	exPkg::gprVal immExt;
	exPkg::gprVal result;

	logic         opValid;
	exPkg::opCmd  opCmdQ;
	exPkg::gprId  opIdRm;
	exPkg::gprVal opVal;
	logic         opFlush;

	// Sign-extend 33-bit immediate
	assign immExt = {{(exPkg::VAL_W - exPkg::IMM_W){inImm[exPkg::IMM_W-1]}}, inImm};

	always_comb begin
		case (inCmd)
			exPkg::CMD_ADD:   result = inValRs + inValRt;
			exPkg::CMD_SUB:   result = inValRs - inValRt;
			exPkg::CMD_AND:   result = inValRs & inValRt;
			exPkg::CMD_OR:    result = inValRs | inValRt;
			exPkg::CMD_XOR:   result = inValRs ^ inValRt;
			exPkg::CMD_MOVIR: result = immExt;
			exPkg::CMD_MOVMR: result = inValRs + immExt;	// Load address
			default:          result = '0;	// NOP and unknown
		endcase
	end

	// Take a new op when empty or the held one leaves this cycle
	assign inReady = !opValid || out.ready;

	always_ff @(posedge clock) begin
		if (rst) begin
			opValid <= 1'b0;
		end else if (inReady) begin
			opValid <= inValid;
		end
	end

	// Payload, no reset
	always_ff @(posedge clock) begin
		if (inReady && inValid) begin
			opCmdQ  <= inCmd;
			opIdRm  <= inIdRm;
			opVal   <= result;
			opFlush <= inFlush;
		end
	end

	assign out.valid   = opValid;
	assign out.cmd     = opCmdQ;
	assign out.idRm    = opIdRm;
	assign out.val     = opVal;
	assign out.memData = '0;	// No load data yet
	assign out.flush   = opFlush;

endmodule

/* hw/exStage2.sv */
/*
 Execute stage 2
 Two-entry op buffer; reads scratch memory for a load at the head
*/
`timescale 1ns/1ps

module exStage2 (
	input  logic          clock,
	input  logic          rst,
	exLaneIf.dst          in,
	exLaneIf.src          out,
	input  logic          memWrEn,
	input  exPkg::memIdx  memWrIdx,
	input  exPkg::gprVal  memWrData
);

	exPkg::opCmd  bufCmd   [exPkg::BUF_DEPTH];
	exPkg::gprId  bufIdRm  [exPkg::BUF_DEPTH];
	exPkg::gprVal bufVal   [exPkg::BUF_DEPTH];
	logic         bufFlush [exPkg::BUF_DEPTH];

	exPkg::bufPtr wrPtr;
	exPkg::bufPtr rdPtr;
	exPkg::bufCnt count;

	logic         push;
	logic         pop;
	exPkg::memIdx rdIdx;
	exPkg::gprVal rdData;

	assign in.ready = count < exPkg::BUF_DEPTH;
	assign push     = in.valid && in.ready;
	assign pop      = out.valid && out.ready;

	always_ff @(posedge clock) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= (wrPtr == exPkg::bufPtr'(exPkg::BUF_DEPTH - 1)) ? '0 :
					wrPtr + exPkg::bufPtr'(1);
			end
			if (pop) begin
				rdPtr <= (rdPtr == exPkg::bufPtr'(exPkg::BUF_DEPTH - 1)) ? '0 :
					rdPtr + exPkg::bufPtr'(1);
			end
			if (push && !pop) count <= count + exPkg::bufCnt'(1);
			else if (pop && !push) count <= count - exPkg::bufCnt'(1);
		end
	end

	// Entry storage, no reset
	always_ff @(posedge clock) begin
		if (push) begin
			bufCmd[wrPtr]   <= in.cmd;
			bufIdRm[wrPtr]  <= in.idRm;
			bufVal[wrPtr]   <= in.val;
			bufFlush[wrPtr] <= in.flush;
		end
	end

	// Word index from head address bits 6:3
	assign rdIdx = bufVal[rdPtr][exPkg::MEM_ADDR_LSB +: exPkg::MEM_IDX_W];

	scratchMem uMem (
		.clock  (clock),
		.wrEn   (memWrEn),
		.wrIdx  (memWrIdx),
		.wrData (memWrData),
		.rdIdx  (rdIdx),
		.rdData (rdData)
	);

	assign out.valid   = count != '0;	// Head visible right after write
	assign out.cmd     = bufCmd[rdPtr];
	assign out.idRm    = bufIdRm[rdPtr];
	assign out.val     = bufVal[rdPtr];
	assign out.flush   = bufFlush[rdPtr];
	assign out.memData = (bufCmd[rdPtr] == exPkg::CMD_MOVMR) ? rdData : '0;

endmodule

/* hw/exStage3.sv */
/*
 Execute stage 3
 Write-back selection: early (Rn2) and final (Rn4) views, held and
 bad-command flags, flush to the zero register
*/
`timescale 1ns/1ps

module exStage3 (
	input  logic          clock,
	input  logic          rst,
	exLaneIf.dst          in,
	output logic          wbValid,
	input  logic          wbReady,
	output exPkg::gprId   wbIdRn2,
	output exPkg::gprId   wbIdRn4,
	output exPkg::gprVal  wbValRn2,
	output exPkg::gprVal  wbValRn4,
	output logic          wbHeld,
	output logic          wbBadCmd
);

	exPkg::gprId  selIdRn2;
	exPkg::gprId  selIdRn4;
	exPkg::gprVal selValRn2;
	exPkg::gprVal selValRn4;
	logic         selHeld;
	logic         selBad;

	always_comb begin
		selIdRn2  = in.idRm;	// Forward by default
		selValRn2 = in.val;
		selIdRn4  = in.idRm;
		selValRn4 = in.val;
		selHeld   = 1'b0;
		selBad    = 1'b0;

		case (in.cmd)
			exPkg::CMD_NOP, exPkg::CMD_ADD, exPkg::CMD_SUB, exPkg::CMD_AND,
			exPkg::CMD_OR, exPkg::CMD_XOR, exPkg::CMD_MOVIR: begin
			end
			exPkg::CMD_MOVMR: begin
				// Data only lands in the final view
				selValRn2 = '0;
				selValRn4 = in.memData;
				selHeld   = 1'b1;
			end
			default: begin
				selBad = 1'b1;	// Unknown cmd, stage-1 value passes on
			end
		endcase

		// Flushed op keeps values, writes go nowhere
		if (in.flush) begin
			selIdRn2 = exPkg::GR_ZZR;
			selIdRn4 = exPkg::GR_ZZR;
			selHeld  = 1'b0;
		end
	end

	// Output register frees up when empty or draining
	assign in.ready = !wbValid || wbReady;

	always_ff @(posedge clock) begin
		if (rst) begin
			wbValid <= 1'b0;
		end else if (in.ready) begin
			wbValid <= in.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (in.ready && in.valid) begin
			wbIdRn2  <= selIdRn2;
			wbValRn2 <= selValRn2;
			wbIdRn4  <= selIdRn4;
			wbValRn4 <= selValRn4;
			wbHeld   <= selHeld;
			wbBadCmd <= selBad;
		end
	end

endmodule

/* hw/scratchMem.sv */
/*
 Scratch data memory
 16 x 64-bit register array, synchronous write, combinational read
*/
`timescale 1ns/1ps

module scratchMem (
	input  logic          clock,
	input  logic          wrEn,
	input  exPkg::memIdx  wrIdx,
	input  exPkg::gprVal  wrData,
	input  exPkg::memIdx  rdIdx,
	output exPkg::gprVal  rdData
);

	exPkg::gprVal mem [exPkg::MEM_WORDS];	// Undefined until written

	always_ff @(posedge clock) begin
		if (wrEn) begin
			mem[wrIdx] <= wrData;
		end
	end

	// Async read for the op at the buffer head
	assign rdData = mem[rdIdx];

endmodule

/* run.sh */
#!/bin/sh
# Build and run the execute lane testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module exLaneTb \
	-f compile.f -o exLaneSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/exLaneSim)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOut" | grep -qx "PASS: all tests"; then
	exit 0
fi
exit 1

/* verif/exLaneTb.sv */
/*
 Execute lane testbench
 Directed tests, reference model feeding an expected write-back queue
*/
`timescale 1ns/1ps

module exLaneTb;

	// One expected write-back tuple
	typedef struct packed {
		exPkg::gprId  idRn2;
		exPkg::gprVal valRn2;
		exPkg::gprId  idRn4;
		exPkg::gprVal valRn4;
		logic         held;
		logic         bad;
	} wbExp;

	logic clock, rst, inValid, inReady, inFlush, wbValid, wbReady, wbHeld, wbBadCmd;
	logic memWrEn;
	exPkg::opCmd  inCmd;
	exPkg::gprId  inIdRm, wbIdRn2, wbIdRn4;
	exPkg::gprVal inValRs, inValRt, wbValRn2, wbValRn4, memWrData;
	exPkg::immVal inImm;
	exPkg::memIdx memWrIdx;

	wbExp         expQ [$];	// Accepted ops awaiting write-back
	exPkg::gprVal shadow [exPkg::MEM_WORDS];	// Mirror of scratchMem
	logic [63:0]  rng = 64'd96060;
	logic [63:0]  bpRng = 64'd96060;	// Separate stream for wbReady
	int           errors = 0;
	int           tests = 0;
	int           issued = 0;
	int           cycles = 0;
	int           wbMode = 0;	// 0 ready, 1 stalled, 2 random

	exLaneTop DUT (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic logic [63:0] xorshift(input logic [63:0] x);
		logic [63:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 7);
		s = s ^ (s << 17);
		return s;
	endfunction

	function automatic logic [63:0] nextRand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// Expected tuple straight from the lane rules
	function automatic wbExp modelOp(input exPkg::opCmd cmd, input exPkg::gprId id,
			input exPkg::gprVal rs, input exPkg::gprVal rt, input exPkg::immVal imm,
			input logic flush);
		wbExp e;
		exPkg::gprVal ext;
		exPkg::gprVal res;
		ext = {{31{imm[32]}}, imm};	// 33 to 64 bit sign extension
		res = 64'd0;	// NOP and unknown give zero
		e.held = 1'b0;
		e.bad = 1'b0;
		case (cmd)
			exPkg::CMD_NOP:   res = 64'd0;
			exPkg::CMD_ADD:   res = rs + rt;
			exPkg::CMD_SUB:   res = rs - rt;
			exPkg::CMD_AND:   res = rs & rt;
			exPkg::CMD_OR:    res = rs | rt;
			exPkg::CMD_XOR:   res = rs ^ rt;
			exPkg::CMD_MOVIR: res = ext;
			exPkg::CMD_MOVMR: begin
				res = rs + ext;	// Load address
				e.held = 1'b1;
			end
			default:          e.bad = 1'b1;
		endcase
		e.idRn2 = flush ? exPkg::GR_ZZR : id;
		e.idRn4 = e.idRn2;
		e.valRn2 = e.held ? 64'd0 : res;	// Early view sees no load data
		e.valRn4 = e.held ? shadow[res[6:3]] : res;
		e.held = e.held && !flush;
		return e;
	endfunction

	task automatic reportMismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		$display("Mismatch %s: got %h expected %h", name, got, exp);
		errors++;
	endtask

	task automatic checkWb();
		wbExp e;
		if (expQ.size() == 0) begin
			$display("Unexpected write-back with no op pending at %0t", $time);
			errors++;
		end else begin
			e = expQ.pop_front();	// In order
			if (wbIdRn2 !== e.idRn2) reportMismatch("wbIdRn2", wbIdRn2, e.idRn2);
			if (wbValRn2 !== e.valRn2) reportMismatch("wbValRn2", wbValRn2, e.valRn2);
			if (wbIdRn4 !== e.idRn4) reportMismatch("wbIdRn4", wbIdRn4, e.idRn4);
			if (wbValRn4 !== e.valRn4) reportMismatch("wbValRn4", wbValRn4, e.valRn4);
			if (wbHeld !== e.held) reportMismatch("wbHeld", wbHeld, e.held);
			if (wbBadCmd !== e.bad) reportMismatch("wbBadCmd", wbBadCmd, e.bad);
		end
	endtask

	// Monitor, pre-edge values
	always @(posedge clock) begin
		if (!rst && wbValid && wbReady) checkWb();
	end

	always @(negedge clock) begin
		if (wbMode == 2) begin
			bpRng = xorshift(bpRng);
			wbReady = bpRng[0];
		end else begin
			wbReady = (wbMode == 0);
		end
	end

	// Mode changes on a rising edge so the wbReady driver sees them cleanly
	task automatic setWbMode(input int mode);
		@(posedge clock);
		wbMode = mode;
		@(negedge clock);
	endtask

	task automatic issueOp(input exPkg::opCmd cmd, input exPkg::gprId id,
			input exPkg::gprVal rs, input exPkg::gprVal rt, input exPkg::immVal imm,
			input logic flush);
		wbExp e;
		e = modelOp(cmd, id, rs, rt, imm, flush);
		issued++;
		inValid = 1'b1;
		inCmd = cmd;
		inIdRm = id;
		inValRs = rs;
		inValRt = rt;
		inImm = imm;
		inFlush = flush;
		while (!inReady) @(negedge clock);	// inReady only moves on rising edges
		@(posedge clock);
		expQ.push_back(e);
		@(negedge clock);
		inValid = 1'b0;
	endtask

	task automatic issueRandom(input exPkg::opCmd cmd, input logic flush);
		issueOp(cmd, exPkg::gprId'(nextRand()), nextRand(), nextRand(),
			exPkg::immVal'(nextRand()), flush);
	endtask

	task automatic writeMem(input exPkg::memIdx idx, input exPkg::gprVal data);
		memWrEn = 1'b1;
		memWrIdx = idx;
		memWrData = data;
		@(negedge clock);
		memWrEn = 1'b0;
		shadow[idx] = data;
	endtask

	task automatic finishTest(input string name, input int e0);
		while (expQ.size() != 0) @(negedge clock);	// Drain the lane
		tests++;
		$display("Test %s done, %0d errors", name, errors - e0);
	endtask

	task automatic aluOps();
		int e0;
		e0 = errors;
		for (int i = 0; i < 15; i++) issueRandom(exPkg::opCmd'(exPkg::CMD_ADD + (i % 5)), 1'b0);
		finishTest("ALU ops", e0);
	endtask

	task automatic immMoves();
		int e0;
		e0 = errors;
		issueOp(exPkg::CMD_MOVIR, 6'd3, 64'd0, 64'd0, 33'h0_0000_0005, 1'b0);
		issueOp(exPkg::CMD_MOVIR, 6'd4, 64'd0, 64'd0, 33'h1_FFFF_FFFF, 1'b0);	// -1
		issueOp(exPkg::CMD_MOVIR, 6'd5, 64'd0, 64'd0, 33'h1_0000_0000, 1'b0);	// Most negative
		issueOp(exPkg::CMD_MOVIR, 6'd6, 64'd0, 64'd0, 33'h0_FFFF_FFFF, 1'b0);	// Most positive
		for (int i = 0; i < 4; i++) issueRandom(exPkg::CMD_MOVIR, 1'b0);
		finishTest("immediate moves", e0);
	endtask

	task automatic loads();
		int e0;
		e0 = errors;
		for (int i = 0; i < exPkg::MEM_WORDS; i++) writeMem(exPkg::memIdx'(i), nextRand());
		for (int i = 0; i < 12; i++) issueRandom(exPkg::CMD_MOVMR, 1'b0);
		finishTest("loads", e0);
	endtask

	task automatic flushMix();
		int e0;
		e0 = errors;
		for (int i = 0; i < 12; i++) begin
			issueRandom((i % 2 == 0) ? exPkg::opCmd'(exPkg::CMD_ADD + (i % 5)) : exPkg::CMD_MOVMR,
				(i % 3) != 2);	// Mostly flushed, a few normal
		end
		finishTest("flush mix", e0);
	endtask

	task automatic backPressure();
		int e0;
		e0 = errors;
		setWbMode(1);
		for (int i = 0; i < 4; i++) issueRandom(exPkg::opCmd'(nextRand() % 8), 1'b0);
		repeat (3) @(negedge clock);
		if (inReady) begin
			$display("inReady stayed high while write-back was stalled");
			errors++;
		end
		setWbMode(2);
		for (int i = 0; i < 36; i++) issueRandom(exPkg::opCmd'(nextRand() % 8), nextRand() % 4 == 0);
		finishTest("back-pressure", e0);
		setWbMode(0);
	endtask

	task automatic badCommands();
		int e0;
		e0 = errors;
		issueRandom(exPkg::CMD_NOP, 1'b0);
		issueRandom(6'h08, 1'b0);	// First unknown code
		issueRandom(6'h3F, 1'b0);
		issueRandom(exPkg::CMD_NOP, 1'b0);
		for (int i = 0; i < 4; i++) issueRandom(exPkg::opCmd'(8 + nextRand() % 56), 1'b0);
		finishTest("bad commands", e0);
	endtask

	// Watchdog, limit grows with every issued op
	initial begin
		while (cycles < 20 * issued + 200) begin
			@(posedge clock);
			cycles++;
		end
		$display("Run timed out waiting for write-back after %0d cycles", cycles);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		rst = 1'b1;
		inValid = 1'b0;
		inCmd = '0;
		inIdRm = '0;
		inValRs = '0;
		inValRt = '0;
		inImm = '0;
		inFlush = 1'b0;
		wbReady = 1'b1;
		memWrEn = 1'b0;
		memWrIdx = '0;
		memWrData = '0;
		repeat (5) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
		aluOps();
		immMoves();
		loads();	// Preloads memory for the later tests
		flushMix();
		backPressure();
		badCommands();
		$display("Summary: %0d tests run, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* verif/exLane_assert.sv */
/*
 Write-back assertions
 Reset, stall stability and load view rules on the lane output
*/
`timescale 1ns/1ps

module exLane_assert (
	input logic          clock,
	input logic          rst,
	input logic          wbValid,
	input logic          wbReady,
	input exPkg::gprId   wbIdRn2,
	input exPkg::gprVal  wbValRn2,
	input exPkg::gprId   wbIdRn4,
	input exPkg::gprVal  wbValRn4,
	input logic          wbHeld,
	input logic          wbBadCmd
);

	// Output register empty once a reset cycle has passed
	aResetLow: assert property (@(posedge clock) rst |=> !wbValid)
		else $error("wbValid high during reset");

	aStallHold: assert property (@(posedge clock) disable iff (rst)
		wbValid && !wbReady |=> wbValid && $stable(wbIdRn2) && $stable(wbValRn2) &&
			$stable(wbIdRn4) && $stable(wbValRn4) && $stable(wbHeld) && $stable(wbBadCmd))
		else $error("Write-back outputs changed while stalled");

	aHeldZero: assert property (@(posedge clock) disable iff (rst)
		wbValid && wbHeld |-> wbValRn2 == '0)	// Load data only in final view
		else $error("wbValRn2 nonzero with wbHeld");

	aHeldIds: assert property (@(posedge clock) disable iff (rst)
		wbValid && wbHeld |-> wbIdRn2 == wbIdRn4)
		else $error("Rn2 and Rn4 ids differ with wbHeld");

endmodule

bind exLaneTop exLane_assert uAssert (.*);
